/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := audio_out_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails on a crash of the simulator or on the fail message in the log
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim.f */
verilog/audio_pkg.sv
verilog/audio_clk_enables.sv
verilog/audio_lpf.sv
verilog/i2s_tx.sv
verilog/sigma_delta_dac.sv
verilog/audio_out.sv
tests/audio_out_tb.sv

/* tests/audio_out_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module audio_out_tb;
	import audio_pkg::*;

	localparam int unsigned clk_rate = 50000000;
	localparam int settle_frames = 40;

	logic      clk;
	logic      reset;
	rate_sel_t rate_sel;
	sample_t   left_in;
	sample_t   right_in;
	logic      i2s_mclk;
	logic      i2s_bclk;
	logic      i2s_lrclk;
	logic      i2s_data;
	logic      dac_l;
	logic      dac_r;

	logic [31:0] lfsr_state;
	int          errors;
	int          errors_at_start;
	int          tests_run;
	int          tests_failed;

	// I2S decoder and frame monitor
	logic        bclk_q;
	logic        lrclk_q;
	chan_t       lr_at_rise;
	logic [15:0] dec_shift;
	sample_t     left_word;
	sample_t     right_word;
	int          frame_count;
	int          clk_count;
	int          lr_rise_count;
	int          lr_rise_clk;
	int          bclk_in_frame;
	logic        seen_rise;
	logic        framing_on;
	logic        range_on;
	sample_t     lo_l;
	sample_t     hi_l;
	sample_t     lo_r;
	sample_t     hi_r;

	audio_out #(
		.clk_rate(clk_rate)
	) audio_out_inst (
		.clk      (clk),
		.reset    (reset),
		.rate_sel (rate_sel),
		.left_in  (left_in),
		.right_in (right_in),
		.i2s_mclk (i2s_mclk),
		.i2s_bclk (i2s_bclk),
		.i2s_lrclk(i2s_lrclk),
		.i2s_data (i2s_data),
		.dac_l    (dac_l),
		.dac_r    (dac_r)
	);

	always #50 clk = ~clk;

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_sample(output sample_t v);
		v = '0;
		for (int i = 0; i < AUDIO_DW; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[AUDIO_DW-2:0], lfsr_state[0]};
		end
	endtask

	// Offset binary reading of a signed level
	function automatic int offset_value(input sample_t s);
		return int'(s) + 32768;
	endfunction

	function automatic sample_t smaller_of(input sample_t a, input sample_t b);
		return (a < b) ? a : b;
	endfunction

	function automatic sample_t larger_of(input sample_t a, input sample_t b);
		return (a > b) ? a : b;
	endfunction

	task automatic compare_sample(input string name, input sample_t actual,
			input sample_t expected);
		if (actual !== expected) begin
			errors++;
			$display("FAIL %0t %s: got %0d expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic compare_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			errors++;
			$display("FAIL %0t %s: got %b expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic compare_count(input string name, input int actual, input int expected,
			input int tol);
		int diff;
		diff = actual - expected;
		if (diff > tol || diff < -tol) begin
			errors++;
			$display("FAIL %0t %s: got %0d expected %0d within %0d", $time, name, actual,
				expected, tol);
		end
	endtask

	task automatic check_in_range(input string name, input sample_t actual, input sample_t lo,
			input sample_t hi);
		if (actual < lo || actual > hi) begin
			errors++;
			$display("FAIL %0t %s: got %0d outside %0d to %0d", $time, name, actual, lo, hi);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("Result: FAILED");
		$finish;
	endtask

	task automatic start_test();
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_at_start);
		end
	endtask

	// Decoded left and right pairs
	task automatic wait_frames(input int n);
		int start;
		int waited;
		start = frame_count;
		waited = 0;
		while (frame_count - start < n) begin
			@(negedge clk);
			waited++;
			if (waited > (n + 2) * 4000) begin
				report_timeout("decoded I2S frames");
			end
		end
	endtask

	task automatic wait_lr_rises(input int n);
		int start;
		int waited;
		start = lr_rise_count;
		waited = 0;
		while (lr_rise_count - start < n) begin
			@(negedge clk);
			waited++;
			if (waited > (n + 2) * 4000) begin
				report_timeout("rising lrclk edges");
			end
		end
	endtask

	task automatic check_idle();
		compare_bit("i2s_bclk", i2s_bclk, 1'b0);
		compare_bit("i2s_lrclk", i2s_lrclk, 1'b0);
		compare_bit("i2s_data", i2s_data, 1'b0);
		compare_bit("dac_l", dac_l, 1'b0);
		compare_bit("dac_r", dac_r, 1'b0);
	endtask

	// Master clock output follows clk, sampled in the middle of each phase
	task automatic check_mclk(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			#25;
			compare_bit("i2s_mclk", i2s_mclk, 1'b1);
			@(negedge clk);
			#25;
			compare_bit("i2s_mclk", i2s_mclk, 1'b0);
		end
		@(negedge clk);
	endtask

	task automatic run_steady(input rate_sel_t rate, input string name);
		sample_t l_val;
		sample_t r_val;
		start_test();
		rate_sel = rate;
		for (int i = 0; i < 8; i++) begin
			rand_sample(l_val);
			rand_sample(r_val);
			left_in = l_val;
			right_in = r_val;
			wait_frames(settle_frames);
			compare_sample("left word", left_word, l_val);
			compare_sample("right word", right_word, r_val);
		end
		end_test(name);
	endtask

	task automatic measure_frame_rate(input rate_sel_t rate, input int fs, input string name);
		int start_clk;
		start_test();
		rate_sel = rate;
		wait_lr_rises(2);
		start_clk = lr_rise_clk;
		wait_lr_rises(64);
		compare_count("clk per frame", (lr_rise_clk - start_clk) / 64, int'(clk_rate) / fs, 9);
		end_test(name);
	endtask

	task automatic count_ones(input int cycles, output int ones_l, output int ones_r);
		ones_l = 0;
		ones_r = 0;
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			ones_l += int'(dac_l);
			ones_r += int'(dac_r);
		end
	endtask

	// Monitor sees only registered outputs, stable at the falling edge
	always @(negedge clk) begin
		if (reset) begin
			bclk_q <= 1'b0;
			lrclk_q <= 1'b0;
			lr_at_rise <= CHAN_LEFT;
			dec_shift <= '0;
			left_word <= '0;
			right_word <= '0;
			frame_count <= 0;
			clk_count <= 0;
			lr_rise_count <= 0;
			lr_rise_clk <= 0;
			bclk_in_frame <= 0;
			seen_rise <= 1'b0;
		end else begin
			clk_count <= clk_count + 1;
			bclk_q <= i2s_bclk;
			lrclk_q <= i2s_lrclk;
			if (i2s_bclk && !bclk_q) begin
				dec_shift <= {dec_shift[14:0], i2s_data};
				bclk_in_frame <= bclk_in_frame + 1;
				lr_at_rise <= chan_t'(i2s_lrclk);
				// Word select differs from the last bit, so this bit is an LSB
				if (chan_t'(i2s_lrclk) != lr_at_rise) begin
					if (lr_at_rise == CHAN_LEFT) begin
						left_word <= {dec_shift[14:0], i2s_data};
					end else begin
						right_word <= {dec_shift[14:0], i2s_data};
						frame_count <= frame_count + 1;
						if (range_on) begin
							check_in_range("left word", left_word, lo_l, hi_l);
							check_in_range("right word", {dec_shift[14:0], i2s_data}, lo_r, hi_r);
						end
					end
				end
			end
			if (i2s_lrclk != lrclk_q) begin
				if (framing_on && i2s_bclk) begin
					errors++;
					$display("Word select changed while bclk was high at %0t", $time);
				end
				if (i2s_lrclk) begin
					if (framing_on && seen_rise) begin
						compare_count("bclk per frame", bclk_in_frame, 32, 0);
					end
					bclk_in_frame <= 0;
					seen_rise <= 1'b1;
					lr_rise_count <= lr_rise_count + 1;
					lr_rise_clk <= clk_count;
				end
			end
		end
	end

	initial begin
		sample_t a_l;
		sample_t a_r;
		sample_t b_l;
		sample_t b_r;
		int ones_l;
		int ones_r;
		clk = 1'b0;
		reset = 1'b1;
		rate_sel = RATE_48K;
		left_in = '0;
		right_in = '0;
		lfsr_state = 32'd70579;
		errors = 0;
		errors_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		framing_on = 1'b0;
		range_on = 1'b0;
		lo_l = '0;
		hi_l = '0;
		lo_r = '0;
		hi_r = '0;

		start_test();
		repeat (3) begin
			@(negedge clk);
			check_idle();
		end
		reset = 1'b0;
		@(negedge clk);
		check_idle();
		end_test("reset");

		start_test();
		check_mclk(4);
		end_test("master clock");

		run_steady(RATE_48K, "steady values 48k");
		run_steady(RATE_96K, "steady values 96k");

		measure_frame_rate(RATE_48K, int'(AUDIO_RATE), "frame rate 48k");
		measure_frame_rate(RATE_96K, 2 * int'(AUDIO_RATE), "frame rate 96k");

		// Framing checked across a rate switch
		start_test();
		framing_on = 1'b1;
		wait_lr_rises(32);
		rate_sel = RATE_48K;
		wait_lr_rises(32);
		framing_on = 1'b0;
		end_test("i2s framing");

		start_test();
		for (int i = 0; i < 3; i++) begin
			rand_sample(a_l);
			rand_sample(a_r);
			left_in = a_l;
			right_in = a_r;
			wait_frames(settle_frames);
			count_ones(65536, ones_l, ones_r);
			compare_count("dac_l ones", ones_l, offset_value(a_l), 2);
			compare_count("dac_r ones", ones_r, offset_value(a_r), 2);
		end
		end_test("sigma-delta density");

		start_test();
		for (int i = 0; i < 4; i++) begin
			rand_sample(a_l);
			rand_sample(a_r);
			left_in = a_l;
			right_in = a_r;
			wait_frames(settle_frames);
			rand_sample(b_l);
			rand_sample(b_r);
			lo_l = smaller_of(a_l, b_l);
			hi_l = larger_of(a_l, b_l);
			lo_r = smaller_of(a_r, b_r);
			hi_r = larger_of(a_r, b_r);
			range_on = 1'b1;
			left_in = b_l;
			right_in = b_r;
			wait_frames(settle_frames);
			range_on = 1'b0;
			compare_sample("left word", left_word, b_l);
			compare_sample("right word", right_word, b_r);
		end
		end_test("filter smoothing");

		$display("tests run %0d, tests failed %0d, checks failed %0d", tests_run, tests_failed,
			errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/audio_clk_enables.sv */
`timescale 1ns/1ns
`default_nettype none

module audio_clk_enables #(
	parameter int unsigned clk_rate = 50000000
) (
	input  logic                 clk,
	input  logic                 reset,
	input  audio_pkg::rate_sel_t rate_sel,
	output logic                 mclk_ce,
	output logic                 i2s_ce,
	output logic                 lpf_ce
);
	import audio_pkg::*;

	// Master enable rate at 48 kHz, 128 x fs
	localparam logic [31:0] ce_rate = 32'(AUDIO_RATE * AUDIO_DW * 8);

	// Overflow threshold of the phase accumulator
	localparam logic [32:0] clk_limit = 33'(clk_rate);

	logic [31:0] phase;
	logic [31:0] step;
	logic [32:0] phase_sum;
	logic [32:0] phase_wrap;
	logic        overflow;
	logic        half_div;
	logic [1:0]  quarter_cnt;

	// Step size follows rate_sel on every accumulator step
	always_comb begin
		if (rate_sel == RATE_96K) begin
			step = ce_rate << 1;
		end else begin
			step = ce_rate;
		end
	end

	// One extra bit so the sum never wraps before the compare
	assign phase_sum  = {1'b0, phase} + {1'b0, step};
	assign phase_wrap = phase_sum - clk_limit;
	assign overflow   = (phase_sum >= clk_limit);

	// Fractional accumulator, one mclk_ce per overflow
	always_ff @(posedge clk) begin
		if (reset) begin
			phase   <= '0;
			mclk_ce <= 1'b0;
		end else begin
			mclk_ce <= overflow;
			if (overflow) begin
				phase <= phase_wrap[31:0];
			end else begin
				phase <= phase_sum[31:0];
			end
		end
	end

	// Bit clock enable on every second master enable
	always_ff @(posedge clk) begin
		if (reset) begin
			half_div <= 1'b0;
			i2s_ce   <= 1'b0;
		end else begin
			i2s_ce <= 1'b0;
			if (mclk_ce) begin
				half_div <= ~half_div;
				i2s_ce   <= half_div;
			end
		end
	end

	// Filter enable on every fourth master enable, 32 x fs
	always_ff @(posedge clk) begin
		if (reset) begin
			quarter_cnt <= '0;
			lpf_ce      <= 1'b0;
		end else begin
			lpf_ce <= 1'b0;
			if (mclk_ce) begin
				quarter_cnt <= quarter_cnt + 2'd1;
				lpf_ce      <= (quarter_cnt == 2'd3);
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/audio_lpf.sv */
`timescale 1ns/1ns
`default_nettype none

module audio_lpf (
	input  logic               clk,
	input  logic               reset,
	input  logic               ce,
	input  audio_pkg::sample_t in_sample,
	output audio_pkg::sample_t out_sample
);
	import audio_pkg::*;

	// Sum of all taps needs LPF_SHIFT guard bits
	localparam int sum_w = AUDIO_DW + LPF_SHIFT;

	sample_t                 taps [LPF_TAPS];
	logic signed [sum_w-1:0] tap_sum;

	// Adder tree over the whole delay line
	always_comb begin
		tap_sum = '0;
		for (int i = 0; i < LPF_TAPS; i++) begin
			tap_sum = tap_sum + {{LPF_SHIFT{taps[i][AUDIO_DW-1]}}, taps[i]};
		end
	end

	// Delay line, newest sample at tap 0
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < LPF_TAPS; i++) begin
				taps[i] <= '0;
			end
		end else if (ce) begin
			taps[0] <= in_sample;
			for (int i = 1; i < LPF_TAPS; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// Mean of the stored taps, one enable behind the delay line
	always_ff @(posedge clk) begin
		if (reset) begin
			out_sample <= '0;
		end else if (ce) begin
			// Upper bits of the sum are the divide by LPF_TAPS
			out_sample <= tap_sum[sum_w-1 -: AUDIO_DW];
		end
	end

endmodule

`default_nettype wire

/* verilog/audio_out.sv */
`timescale 1ns/1ns
`default_nettype none

module audio_out #(
	parameter int unsigned clk_rate = 50000000
) (
	input  logic                 clk,
	input  logic                 reset,
	input  audio_pkg::rate_sel_t rate_sel,
	input  audio_pkg::sample_t   left_in,
	input  audio_pkg::sample_t   right_in,
	output logic                 i2s_mclk,
	output logic                 i2s_bclk,
	output logic                 i2s_lrclk,
	output logic                 i2s_data,
	output logic                 dac_l,
	output logic                 dac_r
);
	import audio_pkg::*;

	logic    i2s_ce;
	logic    lpf_ce;
	sample_t lpf_left;
	sample_t lpf_right;

	// System clock doubles as the I2S master clock
	assign i2s_mclk = clk;

	// Master enable stays internal to the enable generator
	audio_clk_enables #(
		.clk_rate(clk_rate)
	) enables (
		.clk     (clk),
		.reset   (reset),
		.rate_sel(rate_sel),
		.mclk_ce (),
		.i2s_ce  (i2s_ce),
		.lpf_ce  (lpf_ce)
	);

	audio_lpf lpf_l (
		.clk       (clk),
		.reset     (reset),
		.ce        (lpf_ce),
		.in_sample (left_in),
		.out_sample(lpf_left)
	);

	audio_lpf lpf_r (
		.clk       (clk),
		.reset     (reset),
		.ce        (lpf_ce),
		.in_sample (right_in),
		.out_sample(lpf_right)
	);

	i2s_tx i2s (
		.clk       (clk),
		.reset     (reset),
		.ce        (i2s_ce),
		.left_chan (lpf_left),
		.right_chan(lpf_right),
		.bclk      (i2s_bclk),
		.lrclk     (i2s_lrclk),
		.sdata     (i2s_data)
	);

	// One bit stream per channel from the filtered levels
	sigma_delta_dac sd_l (
		.clk    (clk),
		.reset  (reset),
		.level  (lpf_left),
		.bit_out(dac_l)
	);

	sigma_delta_dac sd_r (
		.clk    (clk),
		.reset  (reset),
		.level  (lpf_right),
		.bit_out(dac_r)
	);

endmodule

`default_nettype wire

/* verilog/audio_pkg.sv */
`default_nettype none

package audio_pkg;

	// Base sample rate in Hz
	localparam int unsigned AUDIO_RATE = 48000;

	// Width of one audio sample
	localparam int AUDIO_DW = 16;

	// Moving-average filter length
	localparam int LPF_TAPS = 32;

	// Divide by LPF_TAPS as a right shift
	localparam int LPF_SHIFT = 5;

	// Signed two's-complement audio sample
	typedef logic signed [AUDIO_DW-1:0] sample_t;

	// Output sample rate select
	typedef enum logic {
		RATE_48K = 1'b0,
		RATE_96K = 1'b1
	} rate_sel_t;

	// Word-select phase of the I2S frame
	// Encoding matches the lrclk level
	typedef enum logic {
		CHAN_LEFT  = 1'b0,
		CHAN_RIGHT = 1'b1
	} chan_t;

endpackage

`default_nettype wire

/* verilog/i2s_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_tx (
	input  logic               clk,
	input  logic               reset,
	input  logic               ce,
	input  audio_pkg::sample_t left_chan,
	input  audio_pkg::sample_t right_chan,
	output logic               bclk,
	output logic               lrclk,
	output logic               sdata
);
	import audio_pkg::*;

	// One channel slot is AUDIO_DW bit clocks, two slots per frame
	localparam int cnt_w = $clog2(AUDIO_DW);
	localparam logic [cnt_w-1:0] last_bit = cnt_w'(AUDIO_DW - 1);

	chan_t               chan;
	logic [cnt_w-1:0]    bit_cnt;
	logic [AUDIO_DW-1:0] shift_reg;
	sample_t             right_hold;
	logic                fall_edge;
	logic                slot_end;

	// Next enable turns a high bclk low
	assign fall_edge = ce & bclk;
	assign slot_end  = (bit_cnt == last_bit);

	// Word select follows the channel state
	assign lrclk = (chan == CHAN_RIGHT);

	always_ff @(posedge clk) begin
		if (reset) begin
			bclk <= 1'b0;
		end else if (ce) begin
			bclk <= ~bclk;
		end
	end

	// Slot position, advanced on falling bclk
	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= '0;
		end else if (fall_edge) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// Channel FSM
	// The word select change coincides with the last bit of the previous
	// word, which gives the one-bit delay before the next MSB
	always_ff @(posedge clk) begin
		if (reset) begin
			chan <= CHAN_LEFT;
		end else if (fall_edge && slot_end) begin
			case (chan)
				CHAN_LEFT:  chan <= CHAN_RIGHT;
				CHAN_RIGHT: chan <= CHAN_LEFT;
				default:    chan <= CHAN_LEFT;
			endcase
		end
	end

	// Serial data path
	always_ff @(posedge clk) begin
		if (reset) begin
			shift_reg  <= '0;
			right_hold <= '0;
			sdata      <= 1'b0;
		end else if (fall_edge) begin
			sdata <= shift_reg[AUDIO_DW-1];
			if (slot_end) begin
				if (chan == CHAN_RIGHT) begin
					// Left word start, capture both channels together
					shift_reg  <= left_chan;
					right_hold <= right_chan;
				end else begin
					shift_reg <= right_hold;
				end
			end else begin
				shift_reg <= {shift_reg[AUDIO_DW-2:0], 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/sigma_delta_dac.sv */
`timescale 1ns/1ns
`default_nettype none

module sigma_delta_dac (
	input  logic               clk,
	input  logic               reset,
	input  audio_pkg::sample_t level,
	output logic               bit_out
);
	import audio_pkg::*;

	logic [AUDIO_DW-1:0] offset_level;
	logic [AUDIO_DW:0]   integ;
	logic [AUDIO_DW:0]   integ_next;

	// Signed to offset binary, midscale is 0x8000
	assign offset_level = {~level[AUDIO_DW-1], level[AUDIO_DW-2:0]};

	// Carry is dropped from the running sum before each add
	assign integ_next = {1'b0, integ[AUDIO_DW-1:0]} + {1'b0, offset_level};

	// First-order integrator, one step per clk
	always_ff @(posedge clk) begin
		if (reset) begin
			integ <= '0;
		end else begin
			integ <= integ_next;
		end
	end

	// Carry out of the integrator is the bit stream
	// Ones density is offset_level / 2**AUDIO_DW
	assign bit_out = integ[AUDIO_DW];

endmodule

`default_nettype wire
